// ==== verilog/super6502_config.svh ====
`ifndef SUPER6502_CONFIG_SVH
`define SUPER6502_CONFIG_SVH

// mapper window, decoded on the cpu address.
`define MAPPER_BASE 16'h0200
`define MAPPER_LAST 16'h021F

// peripherals, decoded on the full mapped address.
`define LEDS_ADDR   16'hEFFF
`define IRQ_BASE    16'hEFFC
`define TIMER_BASE  16'hEFF8
`define MULT_BASE   16'hEFF0

`define NUM_PAGES     16
`define RAM_ADDR_BITS 14

`endif

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

    // cpu side.
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // physical page number from the mapper.
    typedef logic [12:0] page_t;

    // page number joined with the 12-bit page offset.
    typedef logic [24:0] mapped_addr_t;

endpackage

// ==== verilog/periph_pkg.sv ====
package periph_pkg;

    typedef logic [15:0] count_t;
    typedef logic [15:0] operand_t;
    typedef logic [31:0] product_t;
    typedef logic [7:0]  irq_vec_t;

    typedef enum logic {
        TMR_IDLE,
        TMR_RUN
    } timer_state_e;

endpackage

// ==== verilog/mapper.sv ====
`timescale 1ns/1ns
`include "super6502_config.svh"

module mapper (
    input  logic                  clk_cpu,
    input  logic                  i_reset,
    input  logic                  i_cs,
    input  logic                  i_we,
    input  logic [3:0]            i_addr,
    input  bus_pkg::cpu_data_t    i_data,
    output bus_pkg::cpu_data_t    o_data,
    input  bus_pkg::cpu_addr_t    i_cpu_addr,
    output bus_pkg::mapped_addr_t o_mapped_addr
);

    bus_pkg::page_t r_pages [`NUM_PAGES];
    bus_pkg::page_t w_sel_entry;
    logic           w_high_byte;

    // odd window bytes carry the upper page bits.
    assign w_high_byte = i_cpu_addr[0];
    assign w_sel_entry = r_pages[i_addr];

    always_ff @(posedge clk_cpu) begin
        if (i_reset) begin
            for (int i = 0; i < `NUM_PAGES; i++) begin
                r_pages[i] <= bus_pkg::page_t'(i);
            end
        end else if (i_cs && i_we) begin
            if (w_high_byte) begin
                r_pages[i_addr][12:8] <= i_data[4:0];
            end else begin
                r_pages[i_addr][7:0] <= i_data;
            end
        end
    end

    always_comb begin
        if (w_high_byte) begin
            o_data = {3'b000, w_sel_entry[12:8]};
        end else begin
            o_data = w_sel_entry[7:0];
        end
    end

    // top nibble picks the page entry.
    assign o_mapped_addr = {r_pages[i_cpu_addr[15:12]], i_cpu_addr[11:0]};

endmodule

// ==== verilog/timer.sv ====
`timescale 1ns/1ns

module timer (
    input  logic               clk_cpu,
    input  logic               i_reset,
    input  logic               i_cs,
    input  logic               i_rwb,
    input  logic [1:0]         i_addr,
    input  bus_pkg::cpu_data_t i_data,
    output bus_pkg::cpu_data_t o_data,
    output logic               o_irq
);

    periph_pkg::count_t       r_reload;
    periph_pkg::count_t       r_count;
    periph_pkg::timer_state_e r_state;
    logic                     r_irq_en;
    logic                     r_expired;
    logic                     w_write;
    logic                     w_running;
    logic                     w_wrap;

    assign w_write   = i_cs && !i_rwb;
    assign w_running = (r_state == periph_pkg::TMR_RUN);
    assign w_wrap    = w_running && (r_count == '0);

    always_ff @(posedge clk_cpu) begin
        if (i_reset) begin
            r_reload  <= '0;
            r_count   <= '0;
            r_state   <= periph_pkg::TMR_IDLE;
            r_irq_en  <= 1'b0;
            r_expired <= 1'b0;
        end else begin
            if (w_wrap) begin
                r_count <= r_reload;
            end else if (w_running) begin
                r_count <= r_count - 1'b1;
            end
            if (w_write) begin
                case (i_addr)
                    2'd0: r_reload[7:0] <= i_data;
                    2'd1: r_reload[15:8] <= i_data;
                    2'd2: begin
                        r_irq_en <= i_data[1];
                        if (i_data[0]) begin
                            r_count <= r_reload;
                            r_state <= periph_pkg::TMR_RUN;
                        end else begin
                            r_state <= periph_pkg::TMR_IDLE;
                        end
                    end
                    default: begin
                        if (i_data[0]) begin
                            r_expired <= 1'b0;
                        end
                    end
                endcase
            end
            // a new expiry beats a clear in the same cycle.
            if (w_wrap) begin
                r_expired <= 1'b1;
            end
        end
    end

    always_comb begin
        case (i_addr)
            2'd0:    o_data = r_count[7:0];
            2'd1:    o_data = r_count[15:8];
            2'd2:    o_data = {6'b0, r_irq_en, w_running};
            default: o_data = {7'b0, r_expired};
        endcase
    end

    assign o_irq = r_expired & r_irq_en;

endmodule

// ==== verilog/multiplier.sv ====
`timescale 1ns/1ns

module multiplier (
    input  logic               clk_cpu,
    input  logic               i_reset,
    input  logic               i_cs,
    input  logic               i_rwb,
    input  logic [2:0]         i_addr,
    input  bus_pkg::cpu_data_t i_data,
    output bus_pkg::cpu_data_t o_data
);

    periph_pkg::operand_t r_a;
    periph_pkg::operand_t r_b;
    periph_pkg::product_t w_product;

    always_ff @(posedge clk_cpu) begin
        if (i_reset) begin
            r_a <= '0;
            r_b <= '0;
        end else if (i_cs && !i_rwb) begin
            case (i_addr)
                3'd0:    r_a[7:0] <= i_data;
                3'd1:    r_a[15:8] <= i_data;
                3'd2:    r_b[7:0] <= i_data;
                3'd3:    r_b[15:8] <= i_data;
                // product bytes are read only.
                default: ;
            endcase
        end
    end

    assign w_product = r_a * r_b;

    always_comb begin
        case (i_addr)
            3'd0:    o_data = r_a[7:0];
            3'd1:    o_data = r_a[15:8];
            3'd2:    o_data = r_b[7:0];
            3'd3:    o_data = r_b[15:8];
            3'd4:    o_data = w_product[7:0];
            3'd5:    o_data = w_product[15:8];
            3'd6:    o_data = w_product[23:16];
            default: o_data = w_product[31:24];
        endcase
    end

endmodule

// ==== verilog/interrupt_controller.sv ====
`timescale 1ns/1ns

module interrupt_controller (
    input  logic                 clk_cpu,
    input  logic                 i_reset,
    input  logic                 i_cs,
    input  logic                 i_rwb,
    input  logic [0:0]           i_addr,
    input  bus_pkg::cpu_data_t   i_data,
    output bus_pkg::cpu_data_t   o_data,
    input  periph_pkg::irq_vec_t i_sources,
    output logic                 o_int
);

    periph_pkg::irq_vec_t r_mask;

    // only the mask is writable.
    always_ff @(posedge clk_cpu) begin
        if (i_reset) begin
            r_mask <= '0;
        end else if (i_cs && !i_rwb && i_addr[0]) begin
            r_mask <= i_data;
        end
    end

    always_comb begin
        if (i_addr[0]) begin
            o_data = r_mask;
        end else begin
            o_data = i_sources;
        end
    end

    // level sensitive, no latching.
    assign o_int = |(i_sources & r_mask);

endmodule

// ==== verilog/ram.sv ====
`timescale 1ns/1ns
`include "super6502_config.svh"

module ram (
    input  logic                      clk_cpu,
    input  logic                      i_cs,
    input  logic                      i_we,
    input  logic [`RAM_ADDR_BITS-1:0] i_addr,
    input  bus_pkg::cpu_data_t        i_data,
    output bus_pkg::cpu_data_t        o_data
);

    bus_pkg::cpu_data_t r_mem [2**`RAM_ADDR_BITS];

    always_ff @(posedge clk_cpu) begin
        if (i_cs && i_we) begin
            r_mem[i_addr] <= i_data;
        end
    end

    // asynchronous read.
    assign o_data = r_mem[i_addr];

endmodule

// ==== verilog/super6502.sv ====
`timescale 1ns/1ns
`include "super6502_config.svh"

module super6502 (
    input  logic               clk_cpu,
    input  logic               i_reset,
    input  bus_pkg::cpu_addr_t i_cpu_addr,
    input  bus_pkg::cpu_data_t i_cpu_data,
    input  logic               i_cpu_rwb,
    output bus_pkg::cpu_data_t o_cpu_data,
    output logic [7:0]         o_cpu_data_oe,
    output logic               o_cpu_resb,
    output logic               o_cpu_irqb,
    input  logic [6:0]         i_ext_irq,
    output logic [7:0]         o_leds
);

    logic                  w_reset;
    bus_pkg::mapped_addr_t w_mapped_addr;
    periph_pkg::irq_vec_t  w_sources;
    logic                  w_timer_irq;
    logic                  w_int;

    logic w_mapper_cs;
    logic w_leds_cs;
    logic w_timer_cs;
    logic w_mult_cs;
    logic w_irq_cs;
    logic w_ram_cs;

    bus_pkg::cpu_data_t w_mapper_data;
    bus_pkg::cpu_data_t w_timer_data;
    bus_pkg::cpu_data_t w_mult_data;
    bus_pkg::cpu_data_t w_irq_data;
    bus_pkg::cpu_data_t w_ram_data;

    // cpu leaves reset one edge after i_reset drops.
    always_ff @(posedge clk_cpu) begin
        if (i_reset) begin
            o_cpu_resb <= 1'b0;
        end else begin
            o_cpu_resb <= 1'b1;
        end
    end

    assign w_reset       = ~o_cpu_resb;
    assign o_cpu_data_oe = {8{i_cpu_rwb}};

    always_comb begin
        w_mapper_cs = (i_cpu_addr >= `MAPPER_BASE) && (i_cpu_addr <= `MAPPER_LAST);
        w_leds_cs   = w_mapped_addr == bus_pkg::mapped_addr_t'(`LEDS_ADDR);
        w_irq_cs    = (w_mapped_addr >= bus_pkg::mapped_addr_t'(`IRQ_BASE))
                   && (w_mapped_addr <= bus_pkg::mapped_addr_t'(`IRQ_BASE + 16'd1));
        w_timer_cs  = (w_mapped_addr >= bus_pkg::mapped_addr_t'(`TIMER_BASE))
                   && (w_mapped_addr <= bus_pkg::mapped_addr_t'(`TIMER_BASE + 16'd3));
        w_mult_cs   = (w_mapped_addr >= bus_pkg::mapped_addr_t'(`MULT_BASE))
                   && (w_mapped_addr <= bus_pkg::mapped_addr_t'(`MULT_BASE + 16'd7));
        w_ram_cs    = ~(w_mapper_cs | w_leds_cs | w_irq_cs | w_timer_cs | w_mult_cs);

        if (w_mapper_cs) begin
            o_cpu_data = w_mapper_data;
        end else if (w_leds_cs) begin
            o_cpu_data = o_leds;
        end else if (w_timer_cs) begin
            o_cpu_data = w_timer_data;
        end else if (w_mult_cs) begin
            o_cpu_data = w_mult_data;
        end else if (w_irq_cs) begin
            o_cpu_data = w_irq_data;
        end else begin
            o_cpu_data = w_ram_data;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (w_reset) begin
            o_leds <= '0;
        end else if (w_leds_cs && !i_cpu_rwb) begin
            o_leds <= i_cpu_data;
        end
    end

    mapper u_mapper (
        .clk_cpu(clk_cpu), .i_reset(w_reset), .i_cs(w_mapper_cs), .i_we(~i_cpu_rwb),
        .i_addr(i_cpu_addr[4:1]), .i_data(i_cpu_data), .o_data(w_mapper_data),
        .i_cpu_addr(i_cpu_addr), .o_mapped_addr(w_mapped_addr)
    );

    timer u_timer (
        .clk_cpu(clk_cpu), .i_reset(w_reset), .i_cs(w_timer_cs), .i_rwb(i_cpu_rwb),
        .i_addr(w_mapped_addr[1:0]), .i_data(i_cpu_data), .o_data(w_timer_data),
        .o_irq(w_timer_irq)
    );

    multiplier u_multiplier (
        .clk_cpu(clk_cpu), .i_reset(w_reset), .i_cs(w_mult_cs), .i_rwb(i_cpu_rwb),
        .i_addr(w_mapped_addr[2:0]), .i_data(i_cpu_data), .o_data(w_mult_data)
    );

    // timer on source 0, external lines above it.
    assign w_sources = {i_ext_irq, w_timer_irq};

    interrupt_controller u_interrupt_controller (
        .clk_cpu(clk_cpu), .i_reset(w_reset), .i_cs(w_irq_cs), .i_rwb(i_cpu_rwb),
        .i_addr(w_mapped_addr[0]), .i_data(i_cpu_data), .o_data(w_irq_data),
        .i_sources(w_sources), .o_int(w_int)
    );

    assign o_cpu_irqb = ~w_int;

    ram u_ram (
        .clk_cpu(clk_cpu), .i_cs(w_ram_cs), .i_we(~i_cpu_rwb),
        .i_addr(w_mapped_addr[`RAM_ADDR_BITS-1:0]), .i_data(i_cpu_data),
        .o_data(w_ram_data)
    );

endmodule

// ==== tests/tb_super6502.sv ====
`timescale 1ns/1ns
`include "super6502_config.svh"

module tb_super6502;

    localparam int T_MAPPER = 0;
    localparam int T_LEDS   = 1;
    localparam int T_IRQ    = 2;
    localparam int T_TIMER  = 3;
    localparam int T_MULT   = 4;
    localparam int T_RAM    = 5;

    logic        clk_cpu = 1'b0;
    logic        i_reset;
    logic [15:0] i_cpu_addr;
    logic [7:0]  i_cpu_data;
    logic        i_cpu_rwb;
    logic [7:0]  o_cpu_data;
    logic [7:0]  o_cpu_data_oe;
    logic        o_cpu_resb;
    logic        o_cpu_irqb;
    logic [6:0]  i_ext_irq;
    logic [7:0]  o_leds;

    // reference state.
    logic [12:0] page_m [`NUM_PAGES];
    logic [7:0]  ram_m [2**`RAM_ADDR_BITS];
    logic [7:0]  leds_m;
    logic [7:0]  mask_m;
    logic [15:0] op_a_m;
    logic [15:0] op_b_m;
    logic        tmr_run_m;
    logic        tmr_ien_m;
    logic        tmr_flag_m;

    string       what_q [$];
    logic [15:0] addr_q [$];
    logic [7:0]  exp_q [$];
    logic [7:0]  got_q [$];
    logic [15:0] written_q [$];
    event        cmp_ev;
    int          test_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    super6502 DUT (
        .clk_cpu(clk_cpu), .i_reset(i_reset), .i_cpu_addr(i_cpu_addr),
        .i_cpu_data(i_cpu_data), .i_cpu_rwb(i_cpu_rwb), .o_cpu_data(o_cpu_data),
        .o_cpu_data_oe(o_cpu_data_oe), .o_cpu_resb(o_cpu_resb), .o_cpu_irqb(o_cpu_irqb),
        .i_ext_irq(i_ext_irq), .o_leds(o_leds)
    );

    always #2 clk_cpu = ~clk_cpu;

    function automatic logic [24:0] ref_map(input logic [15:0] addr);
        return {page_m[addr[15:12]], addr[11:0]};
    endfunction

    function automatic int target_of(input logic [15:0] addr);
        logic [24:0] m;
        m = ref_map(addr);
        if (addr >= `MAPPER_BASE && addr <= `MAPPER_LAST) return T_MAPPER;
        if (m == 25'(`LEDS_ADDR)) return T_LEDS;
        if (m >= 25'(`IRQ_BASE) && m <= 25'(`IRQ_BASE) + 25'd1) return T_IRQ;
        if (m >= 25'(`TIMER_BASE) && m <= 25'(`TIMER_BASE) + 25'd3) return T_TIMER;
        if (m >= 25'(`MULT_BASE) && m <= 25'(`MULT_BASE) + 25'd7) return T_MULT;
        return T_RAM;
    endfunction

    function automatic logic expected_irqb();
        return ~|({i_ext_irq, tmr_flag_m & tmr_ien_m} & mask_m);
    endfunction

    function automatic logic [7:0] ref_read(input logic [15:0] addr);
        logic [24:0] m;
        logic [31:0] product;
        m = ref_map(addr);
        product = 32'(op_a_m) * 32'(op_b_m);
        case (target_of(addr))
            T_MAPPER: return addr[0] ? {3'b000, page_m[addr[4:1]][12:8]}
                                     : page_m[addr[4:1]][7:0];
            T_LEDS:   return leds_m;
            T_IRQ:    return m[0] ? mask_m : {i_ext_irq, tmr_flag_m & tmr_ien_m};
            // count bytes are live and never read here.
            T_TIMER:  return (m[1:0] == 2'd3) ? {7'b0, tmr_flag_m}
                                              : {6'b0, tmr_ien_m, tmr_run_m};
            T_MULT:   return m[2] ? product[8*m[1:0] +: 8]
                                  : (m[1] ? op_b_m[8*m[0] +: 8] : op_a_m[8*m[0] +: 8]);
            default:  return ram_m[m[13:0]];
        endcase
    endfunction

    task automatic update_model(input logic [15:0] addr, input logic [7:0] data);
        logic [24:0] m;
        m = ref_map(addr);
        case (target_of(addr))
            T_MAPPER: begin
                if (addr[0]) page_m[addr[4:1]][12:8] = data[4:0];
                else page_m[addr[4:1]][7:0] = data;
            end
            T_LEDS:  leds_m = data;
            T_IRQ:   if (m[0]) mask_m = data;
            T_TIMER: begin
                if (m[1:0] == 2'd2) begin
                    tmr_ien_m = data[1];
                    tmr_run_m = data[0];
                end else if (m[1:0] == 2'd3 && data[0]) begin
                    tmr_flag_m = 1'b0;
                end
            end
            T_MULT: begin
                if (!m[2] && !m[1]) op_a_m[8*m[0] +: 8] = data;
                else if (!m[2]) op_b_m[8*m[0] +: 8] = data;
            end
            default: ram_m[m[13:0]] = data;
        endcase
    endtask

    task automatic compare(input string what, input logic [15:0] addr,
                           input logic [7:0] exp, input logic [7:0] got);
        what_q.push_back(what);
        addr_q.push_back(addr);
        exp_q.push_back(exp);
        got_q.push_back(got);
        -> cmp_ev;
    endtask

    // drains every queued comparison.
    always @(cmp_ev) begin
        string       what;
        logic [15:0] addr;
        logic [7:0]  exp;
        logic [7:0]  got;
        while (exp_q.size() > 0) begin
            what = what_q.pop_front();
            addr = addr_q.pop_front();
            exp = exp_q.pop_front();
            got = got_q.pop_front();
            assert (got === exp)
            else begin
                $display("** Error at %0t ns: %s at %h, expected %h, got %h",
                         $time, what, addr, exp, got);
                test_errors++;
            end
        end
    end

    // tasks start and end 1 ns after a rising edge.
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        i_cpu_addr = addr;
        i_cpu_data = data;
        i_cpu_rwb = 1'b0;
        #1;
        compare("oe on write", addr, 8'h00, o_cpu_data_oe);
        @(posedge clk_cpu);
        #1;
        i_cpu_rwb = 1'b1;
        update_model(addr, data);
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        i_cpu_addr = addr;
        i_cpu_rwb = 1'b1;
        #1;
        data = o_cpu_data;
        compare("oe on read", addr, 8'hFF, o_cpu_data_oe);
        @(posedge clk_cpu);
        #1;
    endtask

    task automatic check_read(input logic [15:0] addr);
        logic [7:0] exp;
        logic [7:0] got;
        exp = ref_read(addr);
        bus_read(addr, got);
        compare("read", addr, exp, got);
    endtask

    task automatic finish_test(input string name);
        @(posedge clk_cpu);
        #1;
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        logic [7:0]  got;
        logic [15:0] addr;
        int          n;
        n = $urandom(78);
        i_reset = 1'b1;
        i_cpu_addr = '0;
        i_cpu_data = '0;
        i_cpu_rwb = 1'b1;
        i_ext_irq = '0;
        for (int i = 0; i < `NUM_PAGES; i++) page_m[i] = 13'(i);
        leds_m = '0;
        mask_m = '0;
        op_a_m = '0;
        op_b_m = '0;
        tmr_run_m = 1'b0;
        tmr_ien_m = 1'b0;
        tmr_flag_m = 1'b0;

        repeat (2) @(posedge clk_cpu);
        #1;
        compare("resb in reset", 16'h0, 8'h00, {7'b0, o_cpu_resb});
        i_reset = 1'b0;
        n = 0;
        while (o_cpu_resb !== 1'b1 && n < 10) begin
            @(posedge clk_cpu);
            #1;
            n++;
        end
        if (o_cpu_resb !== 1'b1) begin
            $display("timeout: o_cpu_resb did not rise after reset was released");
            test_errors++;
        end
        compare("irqb", 16'h0, 8'h01, {7'b0, o_cpu_irqb});
        compare("leds", 16'h0, 8'h00, o_leds);
        for (int i = 0; i < 2 * `NUM_PAGES; i++) check_read(16'(`MAPPER_BASE + i));
        bus_write(16'h1234, 8'h5A);
        check_read(16'h1234);
        finish_test("reset");

        for (int i = 0; i < 64; i++) begin
            addr = 16'($urandom) & 16'h3FFF;
            if (addr >= `MAPPER_BASE && addr <= `MAPPER_LAST) addr = addr + 16'h0100;
            bus_write(addr, 8'($urandom));
            written_q.push_back(addr);
        end
        foreach (written_q[i]) check_read(written_q[i]);
        // cpu page 1 onto physical page 3.
        bus_write(16'h0202, 8'h03);
        bus_write(16'h0203, 8'h00);
        check_read(16'h0202);
        check_read(16'h0203);
        for (int i = 0; i < 16; i++) begin
            addr = 16'h3000 | (16'($urandom) & 16'h0FFF);
            bus_write(addr, 8'($urandom));
            check_read(addr & 16'h1FFF);
        end
        bus_write(16'h0202, 8'h01);
        finish_test("ram and mapping");

        for (int i = 0; i < 40; i++) begin
            for (int j = 0; j < 4; j++) bus_write(16'(`MULT_BASE + j), 8'($urandom));
            for (int j = 0; j < 8; j++) check_read(16'(`MULT_BASE + j));
        end
        finish_test("multiplier");

        bus_write(`TIMER_BASE, 8'd20);
        bus_write(`TIMER_BASE + 16'd1, 8'd0);
        bus_write(`TIMER_BASE + 16'd2, 8'h03);
        // count was loaded from reload on the enabling edge.
        bus_read(`TIMER_BASE, got);
        compare("count", `TIMER_BASE, 8'd20, got);
        check_read(`TIMER_BASE + 16'd2);
        check_read(`TIMER_BASE + 16'd3);
        got = 8'h00;
        n = 0;
        while (!got[0] && n < 64) begin
            bus_read(`TIMER_BASE + 16'd3, got);
            n++;
        end
        if (!got[0]) begin
            $display("timeout: timer expired flag never set");
            test_errors++;
        end
        tmr_flag_m = 1'b1;
        compare("irqb", i_cpu_addr, {7'b0, expected_irqb()}, {7'b0, o_cpu_irqb});
        bus_write(`IRQ_BASE + 16'd1, 8'h01);
        compare("irqb", i_cpu_addr, {7'b0, expected_irqb()}, {7'b0, o_cpu_irqb});
        check_read(`IRQ_BASE);
        bus_write(`TIMER_BASE + 16'd3, 8'h01);
        compare("irqb", i_cpu_addr, {7'b0, expected_irqb()}, {7'b0, o_cpu_irqb});
        check_read(`TIMER_BASE + 16'd3);
        bus_write(`TIMER_BASE + 16'd2, 8'h00);
        bus_write(`TIMER_BASE + 16'd3, 8'h01);
        bus_write(`IRQ_BASE + 16'd1, 8'h00);
        finish_test("timer");

        for (int i = 0; i < 24; i++) begin
            i_ext_irq = 7'($urandom);
            bus_write(`IRQ_BASE + 16'd1, 8'($urandom));
            compare("irqb", i_cpu_addr, {7'b0, expected_irqb()}, {7'b0, o_cpu_irqb});
            check_read(`IRQ_BASE);
            check_read(`IRQ_BASE + 16'd1);
        end
        bus_write(`LEDS_ADDR, 8'($urandom));
        compare("leds", `LEDS_ADDR, leds_m, o_leds);
        check_read(`LEDS_ADDR);
        finish_test("interrupts and leds");

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/periph_pkg.sv
verilog/mapper.sv
verilog/timer.sv
verilog/multiplier.sv
verilog/interrupt_controller.sv
verilog/ram.sv
verilog/super6502.sv
tests/tb_super6502.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_super6502 \
    -f project.f -Mdir obj_dir -o tb_super6502
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_super6502 > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation run exited with an error, see sim.log"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see sim.log"
exit 1
